// ==== tb.f ====
logic/tgen_cfg_pkg.sv
logic/tgen_flow_pkg.sv
logic/tgen_cfg_regs.sv
logic/slot_timer.sv
logic/token_shaper.sv
logic/flow_arbiter.sv
logic/frame_emitter.sv
logic/tgen_top.sv
verif/tgen_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the traffic generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tgen_tb -f tb.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtgen_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q -F '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verif/tgen_tb.sv ====
// testbench: clock, reset, lfsr stimulus, token-bucket reference model, compare tasks, timeout
`default_nettype none

module tgen_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // test phase lengths in clock cycles
    localparam int rst_cycles     = 10;
    localparam int setup_cycles   = 80;
    localparam int run1_cycles    = 12000;
    localparam int run2_cycles    = 4000;
    localparam int stop_cycles    = 200;
    localparam int timeout_cycles = rst_cycles + 2 * setup_cycles + run1_cycles
                                    + run2_cycles + 2 * stop_cycles + 1000;

    logic                                clk;
    logic                                rst_n;
    logic                                cfg_wr;
    tgen_cfg_pkg::cfg_addr_e             cfg_addr;
    logic [tgen_cfg_pkg::flow_id_w-1:0]  cfg_flow;
    logic [15:0]                         cfg_wdata;
    logic                                desc_valid;
    tgen_flow_pkg::frame_desc_t          desc;

    logic [31:0] lfsr_state = 32'h7c89_7d6d;
    int          cycle_cnt  = 0;

    // ****************************************
    // reference model state, mirrors dut registers
    // ****************************************
    tgen_cfg_pkg::flow_cfg_t      m_cfg [tgen_cfg_pkg::num_flows];
    logic [15:0]                  m_slot_len;
    logic                         m_start;
    logic                         m_done;
    logic [15:0]                  m_cyc;
    logic                         m_sw;
    logic [tgen_cfg_pkg::slot_w-1:0] m_idx;
    tgen_flow_pkg::shaper_state_e m_state [tgen_cfg_pkg::num_flows];
    int                           m_tok [tgen_cfg_pkg::num_flows];
    int                           m_charge [tgen_cfg_pkg::num_flows];
    logic [tgen_cfg_pkg::num_flows-1:0] m_req;
    int                           m_bcnt;
    int                           m_last;
    logic [15:0]                  m_seq [tgen_cfg_pkg::num_flows];

    // strobe inputs as the dut sees them at the next edge
    logic                         p_wr;
    tgen_cfg_pkg::cfg_addr_e      p_addr;
    logic [tgen_cfg_pkg::flow_id_w-1:0] p_flow;
    logic [15:0]                  p_data;
    logic                         model_live;

    // per-slot bookkeeping
    bit fast [tgen_cfg_pkg::num_flows];
    bit slot_armed [tgen_cfg_pkg::num_flows];
    int slot_frames [tgen_cfg_pkg::num_flows];
    int frames_total;
    int last_desc_cyc;
    int last_gap;
    bit expect_quiet;

    tgen_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_flow   (cfg_flow),
        .cfg_wdata  (cfg_wdata),
        .desc_valid (desc_valid),
        .desc       (desc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************
    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r          = {r[30:0], b};
        end
        return r;
    endfunction

    // one token per byte plus fixed overhead
    function automatic int cost_of(input int len);
        return len + tgen_cfg_pkg::frame_overhead;
    endfunction

    // cycles busy stays high after a grant
    function automatic int window_of(input int cost);
        return (cost + tgen_cfg_pkg::beat_bytes - 1) / tgen_cfg_pkg::beat_bytes + 1;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_desc(input tgen_flow_pkg::frame_desc_t got,
                              input tgen_flow_pkg::frame_desc_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch desc: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int lo, input int hi);
        if (got < lo || got > hi) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h to 0x%h",
                                     name, got, lo, hi));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // single strobe write, one idle cycle after
    task automatic cfg_write(input tgen_cfg_pkg::cfg_addr_e addr,
                             input logic [tgen_cfg_pkg::flow_id_w-1:0] flow,
                             input logic [15:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_flow  <= flow;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    // random lengths, rates and sizes; saturate gives every flow a huge bucket
    task automatic program_flows(input bit saturate);
        int len;
        int cost;
        int rate;
        int bucket;
        for (int f = 0; f < tgen_cfg_pkg::num_flows; f++) begin
            len  = 20 + int'(rand_bits(7));
            cost = cost_of(len);
            if (saturate) begin
                rate   = 16'h4000;
                bucket = 16'h4000;
                fast[f] = 1'b1;
            end else if (f < 2) begin
                // at least one frame per slot
                rate   = cost + int'(rand_bits(8));
                bucket = rate + int'(rand_bits(9));
                fast[f] = 1'b1;
            end else begin
                rate   = int'(rand_bits(8));
                bucket = int'(rand_bits(10));
                fast[f] = 1'b0;
            end
            cfg_write(tgen_cfg_pkg::addr_pkt_len, f[1:0], 16'(len));
            cfg_write(tgen_cfg_pkg::addr_bucket_size, f[1:0], 16'(bucket));
            cfg_write(tgen_cfg_pkg::addr_rate, f[1:0], 16'(rate));
        end
        // slot long enough for four full busy windows
        cfg_write(tgen_cfg_pkg::addr_slot_len, 2'd0, 16'(128 + int'(rand_bits(6))));
    endtask

    // frames per slot within the bucket allowance, fast flows never idle
    task automatic close_slot();
        int cost;
        for (int f = 0; f < tgen_cfg_pkg::num_flows; f++) begin
            cost = cost_of(m_cfg[f].pkt_len);
            if (slot_armed[f] && m_state[f] == tgen_flow_pkg::st_running) begin
                check_count($sformatf("frames of flow %0d in slot", f), slot_frames[f],
                            fast[f] ? 1 : 0, int'(m_cfg[f].bucket_size) / cost + 1);
            end
            slot_armed[f]  = (m_state[f] == tgen_flow_pkg::st_running) ||
                             (m_state[f] == tgen_flow_pkg::st_wait_period && m_idx == '0);
            slot_frames[f] = 0;
        end
    endtask

    // ****************************************
    // model step, one per clock edge
    // ****************************************
    task automatic compare_and_step();
        int  pick;
        int  c;
        int  cst;
        int  old_tok;
        int  nxt;
        bit  found;
        bit  grant;
        tgen_flow_pkg::frame_desc_t exp_desc;
        // round-robin pick from last edge's requests
        found = 1'b0;
        pick  = m_last;
        for (int i = 1; i <= tgen_cfg_pkg::num_flows; i++) begin
            c = (m_last + i) % tgen_cfg_pkg::num_flows;
            if (!found && m_req[c]) begin
                found = 1'b1;
                pick  = c;
            end
        end
        grant = found && (m_bcnt == 0);
        if (expect_quiet && desc_valid) begin
            report_failure("a descriptor was issued while traffic had to be stopped");
        end
        // spacing of the dut's own descriptors
        if (desc_valid === 1'b1) begin
            if (frames_total > 0 && cycle_cnt - last_desc_cyc < last_gap) begin
                report_failure("two descriptors came closer than the busy window");
            end
            last_desc_cyc = cycle_cnt;
            last_gap      = window_of(cost_of(int'(desc.pkt_len))) + 1;
        end
        check_flag("desc_valid", desc_valid, grant);
        if (m_sw) begin
            close_slot();
        end
        if (grant) begin
            exp_desc.flow    = tgen_cfg_pkg::flow_id_w'(pick);
            exp_desc.pkt_len = m_cfg[pick].pkt_len;
            exp_desc.seq     = m_seq[pick];
            check_desc(desc, exp_desc);
            slot_frames[pick]++;
            frames_total++;
        end
        // token buckets
        for (int f = 0; f < tgen_cfg_pkg::num_flows; f++) begin
            cst      = cost_of(m_cfg[f].pkt_len);
            old_tok  = m_tok[f];
            m_req[f] = (old_tok >= cst);
            if (!m_start) begin
                m_state[f] = tgen_flow_pkg::st_idle;
                m_tok[f]   = 0;
            end else begin
                case (m_state[f])
                    tgen_flow_pkg::st_idle: begin
                        m_tok[f]   = 0;
                        m_state[f] = tgen_flow_pkg::st_wait_cfg;
                    end
                    tgen_flow_pkg::st_wait_cfg: begin
                        if (m_done) begin
                            m_state[f] = tgen_flow_pkg::st_wait_period;
                        end
                    end
                    tgen_flow_pkg::st_wait_period: begin
                        if (m_sw && m_idx == '0) begin
                            m_tok[f]   = (m_cfg[f].rate > m_cfg[f].bucket_size) ?
                                         int'(m_cfg[f].bucket_size) : int'(m_cfg[f].rate);
                            m_state[f] = tgen_flow_pkg::st_running;
                        end
                    end
                    default: begin
                        nxt = m_sw ? old_tok + int'(m_cfg[f].rate) - m_charge[f]
                                   : old_tok - m_charge[f];
                        if (nxt < 0) begin
                            report_failure($sformatf("bucket of flow %0d went negative", f));
                        end
                        if (m_sw && nxt > int'(m_cfg[f].bucket_size)) begin
                            nxt = int'(m_cfg[f].bucket_size);
                        end
                        m_tok[f] = nxt;
                    end
                endcase
            end
            m_charge[f] = (grant && pick == f) ? cst : 0;
        end
        // slot timer
        if (!m_start) begin
            m_idx = '0;
            m_cyc = '0;
            m_sw  = 1'b0;
        end else begin
            if (m_sw) begin
                m_idx = m_idx + 1'b1;
            end
            if (m_cyc == m_slot_len - 16'd1) begin
                m_cyc = '0;
                m_sw  = 1'b1;
            end else begin
                m_cyc = m_cyc + 16'd1;
                m_sw  = 1'b0;
            end
        end
        // emitter busy window and sequence numbers
        if (grant) begin
            m_bcnt       = window_of(cost_of(m_cfg[pick].pkt_len));
            m_seq[pick]  = m_seq[pick] + 16'd1;
            m_last       = pick;
        end else if (m_bcnt > 0) begin
            m_bcnt--;
        end
        // register block
        if (p_wr) begin
            case (p_addr)
                tgen_cfg_pkg::addr_pkt_len:     m_cfg[p_flow].pkt_len     = p_data[11:0];
                tgen_cfg_pkg::addr_bucket_size: m_cfg[p_flow].bucket_size = p_data;
                tgen_cfg_pkg::addr_rate:        m_cfg[p_flow].rate        = p_data;
                tgen_cfg_pkg::addr_slot_len:    m_slot_len                = p_data;
                tgen_cfg_pkg::addr_ctrl: begin
                    m_start = p_data[0];
                    m_done  = p_data[1];
                end
                default: begin
                end
            endcase
        end
    endtask

    // sample where outputs are stable
    always @(negedge clk) begin
        if (rst_n) begin
            if (model_live) begin
                compare_and_step();
            end
            model_live = 1'b1;
            p_wr       = cfg_wr;
            p_addr     = cfg_addr;
            p_flow     = cfg_flow;
            p_data     = cfg_wdata;
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles", timeout_cycles));
        end
    end

    // ****************************************
    // test sequence
    // ****************************************
    initial begin
        cfg_wr    = 1'b0;
        cfg_addr  = tgen_cfg_pkg::addr_pkt_len;
        cfg_flow  = '0;
        cfg_wdata = '0;
        rst_n     = 1'b0;
        m_slot_len = '0;
        m_start    = 1'b0;
        m_done     = 1'b0;
        m_cyc      = '0;
        m_sw       = 1'b0;
        m_idx      = '0;
        m_req      = '0;
        m_bcnt     = 0;
        m_last     = tgen_cfg_pkg::num_flows - 1;
        model_live = 1'b0;
        p_wr       = 1'b0;
        frames_total  = 0;
        last_desc_cyc = 0;
        last_gap      = 0;
        expect_quiet  = 1'b1;
        for (int f = 0; f < tgen_cfg_pkg::num_flows; f++) begin
            m_cfg[f]       = '0;
            m_state[f]     = tgen_flow_pkg::st_idle;
            m_tok[f]       = 0;
            m_charge[f]    = 0;
            m_seq[f]       = '0;
            slot_armed[f]  = 1'b0;
            slot_frames[f] = 0;
        end
        wait_cycles(rst_cycles);
        rst_n <= 1'b1;

        // random rates, start first, config done a little later
        program_flows(1'b0);
        cfg_write(tgen_cfg_pkg::addr_ctrl, 2'd0, 16'h0001);
        wait_cycles(20);
        cfg_write(tgen_cfg_pkg::addr_ctrl, 2'd0, 16'h0003);
        expect_quiet = 1'b0;
        wait_cycles(run1_cycles);

        // stop, then restart with all flows saturated
        cfg_write(tgen_cfg_pkg::addr_ctrl, 2'd0, 16'h0000);
        wait_cycles(50);
        expect_quiet = 1'b1;
        wait_cycles(stop_cycles - 50);
        program_flows(1'b1);
        cfg_write(tgen_cfg_pkg::addr_ctrl, 2'd0, 16'h0003);
        expect_quiet = 1'b0;
        wait_cycles(run2_cycles);

        cfg_write(tgen_cfg_pkg::addr_ctrl, 2'd0, 16'h0000);
        wait_cycles(50);
        expect_quiet = 1'b1;
        wait_cycles(stop_cycles - 50);

        for (int f = 0; f < tgen_cfg_pkg::num_flows; f++) begin
            check_count($sformatf("frames of flow %0d", f), int'(m_seq[f]), 1, 32'hffff);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/tgen_top.sv ====
// traffic generator top: register block, slot timer, four shapers, arbiter, emitter
`default_nettype none

module tgen_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               cfg_wr,
    input  tgen_cfg_pkg::cfg_addr_e                 cfg_addr,
    input  wire logic [tgen_cfg_pkg::flow_id_w-1:0] cfg_flow,
    input  wire logic [15:0]                        cfg_wdata,
    output logic                                    desc_valid,
    output tgen_flow_pkg::frame_desc_t              desc
);

    tgen_cfg_pkg::flow_cfg_t [tgen_cfg_pkg::num_flows-1:0] flow_cfg;

    logic [15:0]                        slot_len;
    logic                               start;
    logic                               cfg_done;
    logic                               slot_switch;
    logic [tgen_cfg_pkg::slot_w-1:0]    slot_idx;
    logic [tgen_cfg_pkg::num_flows-1:0] req;
    logic [tgen_cfg_pkg::num_flows-1:0] sel;
    logic [tgen_cfg_pkg::flow_id_w-1:0] grant_flow;
    logic                               busy;

    tgen_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_flow  (cfg_flow),
        .cfg_wdata (cfg_wdata),
        .flow_cfg  (flow_cfg),
        .slot_len  (slot_len),
        .start     (start),
        .cfg_done  (cfg_done)
    );

    slot_timer u_slot_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .slot_len    (slot_len),
        .slot_switch (slot_switch),
        .slot_idx    (slot_idx)
    );

    // one shaper per flow
    for (genvar f = 0; f < tgen_cfg_pkg::num_flows; f++) begin : g_shaper
        token_shaper u_shaper (
            .clk         (clk),
            .rst_n       (rst_n),
            .start       (start),
            .cfg_done    (cfg_done),
            .slot_switch (slot_switch),
            .slot_idx    (slot_idx),
            .cfg         (flow_cfg[f]),
            .sel         (sel[f]),
            .req         (req[f])
        );
    end

    flow_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .busy       (busy),
        .sel        (sel),
        .grant_flow (grant_flow)
    );

    frame_emitter u_emitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .grant_flow (grant_flow),
        .flow_cfg   (flow_cfg),
        .busy       (busy),
        .desc_valid (desc_valid),
        .desc       (desc)
    );

endmodule

`default_nettype wire

// ==== logic/frame_emitter.sv ====
// descriptor per grant, per-flow sequence counters, busy window from frame wire time
`default_nettype none

module frame_emitter (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    input  wire logic [tgen_cfg_pkg::num_flows-1:0]            sel,
    input  wire logic [tgen_cfg_pkg::flow_id_w-1:0]            grant_flow,
    input  tgen_cfg_pkg::flow_cfg_t [tgen_cfg_pkg::num_flows-1:0] flow_cfg,
    output logic                                               busy,
    output logic                                               desc_valid,
    output tgen_flow_pkg::frame_desc_t                         desc
);

    logic [tgen_flow_pkg::seq_w-1:0] seq_cnt [tgen_cfg_pkg::num_flows];
    logic [tgen_cfg_pkg::tok_w-1:0]  cost;
    logic [tgen_cfg_pkg::tok_w-1:0]  busy_load;
    logic [tgen_cfg_pkg::tok_w-1:0]  busy_cnt;
    logic                            grant;

    assign grant = |sel;
    assign cost  = tgen_cfg_pkg::frame_cost(flow_cfg[grant_flow].pkt_len);
    // ceil(cost / beat_bytes) beats plus one for charge and req to settle
    assign busy_load = (cost + tgen_cfg_pkg::tok_w'(tgen_cfg_pkg::beat_bytes - 1))
                       / tgen_cfg_pkg::tok_w'(tgen_cfg_pkg::beat_bytes)
                       + tgen_cfg_pkg::tok_w'(1);
    assign busy = (busy_cnt != '0);

    // ****************************************
    // descriptor and sequence numbers
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            desc_valid <= 1'b0;
            for (int i = 0; i < tgen_cfg_pkg::num_flows; i++) begin
                seq_cnt[i] <= '0;
            end
        end else begin
            desc_valid <= grant;
            if (grant) begin
                seq_cnt[grant_flow] <= seq_cnt[grant_flow] + 1'b1;
            end
        end
    end

    // payload only, qualified by desc_valid
    always_ff @(posedge clk) begin
        if (grant) begin
            desc.flow    <= grant_flow;
            desc.pkt_len <= flow_cfg[grant_flow].pkt_len;
            desc.seq     <= seq_cnt[grant_flow];
        end
    end

    // busy window counts down from the grant edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (grant) begin
            busy_cnt <= busy_load;
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/flow_arbiter.sv ====
// round-robin grant among shaper requests while the emitter is idle
`default_nettype none

module flow_arbiter (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [tgen_cfg_pkg::num_flows-1:0] req,
    input  wire logic                               busy,
    output logic [tgen_cfg_pkg::num_flows-1:0]      sel,
    output logic [tgen_cfg_pkg::flow_id_w-1:0]      grant_flow
);

    // last granted flow, search starts one above it
    logic [tgen_cfg_pkg::flow_id_w-1:0] last_flow;
    logic [tgen_cfg_pkg::flow_id_w-1:0] cand;
    logic                               found;

    // ****************************************
    // round-robin pick
    // ****************************************
    always_comb begin
        grant_flow = last_flow;
        found      = 1'b0;
        cand       = last_flow;
        // i = num_flows wraps back to last_flow itself
        for (int i = 1; i <= tgen_cfg_pkg::num_flows; i++) begin
            cand = last_flow + tgen_cfg_pkg::flow_id_w'(i);
            if (!found && req[cand]) begin
                found      = 1'b1;
                grant_flow = cand;
            end
        end
    end

    // no grant while the emitter is busy
    always_comb begin
        sel = '0;
        if (found && !busy) begin
            sel[grant_flow] = 1'b1;
        end
    end

    // flow 0 goes first after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_flow <= tgen_cfg_pkg::flow_id_w'(tgen_cfg_pkg::num_flows - 1);
        end else if (|sel) begin
            last_flow <= grant_flow;
        end
    end

    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(sel)
    );

endmodule

`default_nettype wire

// ==== logic/token_shaper.sv ====
// per-flow token bucket: start and sync states, cost charging, registered request
`default_nettype none

module token_shaper (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start,
    input  wire logic                          cfg_done,
    input  wire logic                          slot_switch,
    input  wire logic [tgen_cfg_pkg::slot_w-1:0] slot_idx,
    input  tgen_cfg_pkg::flow_cfg_t            cfg,
    input  wire logic                          sel,
    output logic                               req
);

    tgen_flow_pkg::shaper_state_e state;

    logic [tgen_cfg_pkg::tok_w-1:0] tokens;
    // tokens owed for the frame granted last cycle
    logic [tgen_cfg_pkg::tok_w-1:0] charge;
    logic [tgen_cfg_pkg::tok_w-1:0] cost;
    // one extra bit so rate on top of a full bucket does not wrap
    logic [tgen_cfg_pkg::tok_w:0]   refill;
    logic [tgen_cfg_pkg::tok_w-1:0] first_load;
    logic                           period_start;

    assign cost         = tgen_cfg_pkg::frame_cost(cfg.pkt_len);
    assign refill       = {1'b0, tokens} + {1'b0, cfg.rate} - {1'b0, charge};
    assign period_start = slot_switch && (slot_idx == '0);
    // opening load is rate, never above the bucket
    assign first_load   = (cfg.rate > cfg.bucket_size) ? cfg.bucket_size : cfg.rate;

    // ****************************************
    // pending charge
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            charge <= '0;
        end else if (sel) begin
            charge <= cost;
        end else begin
            charge <= '0;
        end
    end

    // ****************************************
    // bucket state machine
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= tgen_flow_pkg::st_idle;
            tokens <= '0;
        end else if (!start) begin
            // start dropped, empty the bucket from any state
            state  <= tgen_flow_pkg::st_idle;
            tokens <= '0;
        end else begin
            case (state)
                tgen_flow_pkg::st_idle: begin
                    tokens <= '0;
                    state  <= tgen_flow_pkg::st_wait_cfg;
                end
                tgen_flow_pkg::st_wait_cfg: begin
                    if (cfg_done) begin
                        state <= tgen_flow_pkg::st_wait_period;
                    end
                end
                tgen_flow_pkg::st_wait_period: begin
                    if (period_start) begin
                        tokens <= first_load;
                        state  <= tgen_flow_pkg::st_running;
                    end
                end
                tgen_flow_pkg::st_running: begin
                    if (slot_switch) begin
                        // add one slot of rate, clip at bucket size
                        if (refill > {1'b0, cfg.bucket_size}) begin
                            tokens <= cfg.bucket_size;
                        end else begin
                            tokens <= refill[tgen_cfg_pkg::tok_w-1:0];
                        end
                    end else begin
                        tokens <= tokens - charge;
                    end
                end
                default: begin
                    state <= tgen_flow_pkg::st_idle;
                end
            endcase
        end
    end

    // request one cycle after the bucket covers a frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= 1'b0;
        end else begin
            req <= (tokens >= cost);
        end
    end

    a_bucket_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == tgen_flow_pkg::st_running |-> tokens <= cfg.bucket_size
    );

    // arbiter only grants a requesting flow
    a_sel_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        sel |-> req
    );

endmodule

`default_nettype wire

// ==== logic/slot_timer.sv ====
// slot length counter: slot switch pulse and wrapping slot index
`default_nettype none

module slot_timer (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            start,
    input  wire logic [15:0]                     slot_len,
    output logic                                 slot_switch,
    output logic [tgen_cfg_pkg::slot_w-1:0]      slot_idx
);

    // cycles elapsed in the current slot
    logic [15:0] cyc_cnt;

    // ****************************************
    // slot divider
    // ****************************************
    // first pulse lands slot_len cycles after start is seen high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_cnt     <= '0;
            slot_switch <= 1'b0;
        end else if (!start) begin
            cyc_cnt     <= '0;
            slot_switch <= 1'b0;
        end else if (cyc_cnt == slot_len - 16'd1) begin
            cyc_cnt     <= '0;
            slot_switch <= 1'b1;
        end else begin
            cyc_cnt     <= cyc_cnt + 16'd1;
            slot_switch <= 1'b0;
        end
    end

    // index steps after each pulse, so the first pulse carries 0
    // wraps at 1024 by width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_idx <= '0;
        end else if (!start) begin
            slot_idx <= '0;
        end else if (slot_switch) begin
            slot_idx <= slot_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tgen_cfg_regs.sv ====
// strobe-written configuration registers: per-flow config, slot length, start and done levels
`default_nettype none

module tgen_cfg_regs (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    input  wire logic                                          cfg_wr,
    input  tgen_cfg_pkg::cfg_addr_e                            cfg_addr,
    input  wire logic [tgen_cfg_pkg::flow_id_w-1:0]            cfg_flow,
    input  wire logic [15:0]                                   cfg_wdata,
    output tgen_cfg_pkg::flow_cfg_t [tgen_cfg_pkg::num_flows-1:0] flow_cfg,
    output logic [15:0]                                        slot_len,
    output logic                                               start,
    output logic                                               cfg_done
);

    // ****************************************
    // write decode
    // ****************************************
    // one strobe is one write, flow index picks the per-flow entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flow_cfg <= '0;
            slot_len <= '0;
            start    <= 1'b0;
            cfg_done <= 1'b0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                tgen_cfg_pkg::addr_pkt_len: begin
                    // upper four data bits ignored
                    flow_cfg[cfg_flow].pkt_len <= cfg_wdata[tgen_cfg_pkg::len_w-1:0];
                end
                tgen_cfg_pkg::addr_bucket_size: begin
                    flow_cfg[cfg_flow].bucket_size <= cfg_wdata;
                end
                tgen_cfg_pkg::addr_rate: begin
                    flow_cfg[cfg_flow].rate <= cfg_wdata;
                end
                tgen_cfg_pkg::addr_slot_len: begin
                    slot_len <= cfg_wdata;
                end
                tgen_cfg_pkg::addr_ctrl: begin
                    // bit 0 start, bit 1 config done, both held as levels
                    start    <= cfg_wdata[0];
                    cfg_done <= cfg_wdata[1];
                end
                default: begin
                    // status and unmapped addresses hold everything
                end
            endcase
        end
    end

    // status is read-only
    a_no_status_wr: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr |-> cfg_addr != tgen_cfg_pkg::addr_status
    );

endmodule

`default_nettype wire

// ==== logic/tgen_flow_pkg.sv ====
// flow-side types: shaper state enum, frame descriptor struct
`default_nettype none

package tgen_flow_pkg;

    // per-flow frame counter width
    localparam int seq_w = 16;

    // token bucket states
    // idle        bucket empty, waiting for start
    // wait_cfg    started, waiting for config done
    // wait_period waiting for the index-0 slot switch
    // running     bucket refills per slot
    typedef enum logic [1:0] {
        st_idle        = 2'd0,
        st_wait_cfg    = 2'd1,
        st_wait_period = 2'd2,
        st_running     = 2'd3
    } shaper_state_e;

    // one descriptor per emitted frame, 30 bits
    typedef struct packed {
        logic [tgen_cfg_pkg::flow_id_w-1:0] flow;
        logic [tgen_cfg_pkg::len_w-1:0]     pkt_len;
        logic [seq_w-1:0]                   seq;
    } frame_desc_t;

endpackage

`default_nettype wire

// ==== logic/tgen_cfg_pkg.sv ====
// configuration-side sizes, register address map, per-flow config struct, frame cost function
`default_nettype none

package tgen_cfg_pkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int num_flows      = 4;
    localparam int flow_id_w      = 2;
    localparam int len_w          = 12;
    localparam int tok_w          = 16;
    localparam int slot_w         = 10;
    // one token per byte, overhead added on top of packet length
    localparam int frame_overhead = 4;
    // emitter moves this many bytes per cycle
    localparam int beat_bytes     = 8;

    // register map for the strobe write port
    typedef enum logic [3:0] {
        addr_pkt_len     = 4'h0,
        addr_bucket_size = 4'h1,
        addr_rate        = 4'h2,
        addr_slot_len    = 4'h3,
        addr_ctrl        = 4'h4,
        addr_status      = 4'h5
    } cfg_addr_e;

    // per-flow settings, 44 bits
    typedef struct packed {
        logic [len_w-1:0] pkt_len;
        logic [tok_w-1:0] bucket_size;
        logic [tok_w-1:0] rate;
    } flow_cfg_t;

    // tokens charged for one frame of the given length
    function automatic logic [tok_w-1:0] frame_cost(input logic [len_w-1:0] pkt_len);
        return tok_w'(pkt_len) + tok_w'(frame_overhead);
    endfunction

endpackage

`default_nettype wire
